// ==== Bender.yml ====
package:
  name: arm_pipeline

sources:
  - src/armPkg.sv
  - src/armIfs.sv
  - src/decodeStage.sv
  - src/registerFile.sv
  - src/executeStage.sv
  - src/armPipeline.sv
  - target: simulation
    files:
      - tb/tbArmPipeline.sv

// ==== src/armIfs.sv ====
// operand read path between decode and the register file.
interface regReadIf import armPkg::*; ();

   regAddrT rnAddr;
   regAddrT rmAddr;
   dataT    rnData;
   dataT    rmData;

   modport requester (
      output rnAddr,
      output rmAddr,
      input  rnData,
      input  rmData
   );

   modport responder (
      input  rnAddr,
      input  rmAddr,
      output rnData,
      output rmData
   );

endinterface

// one decoded instruction, handed from decode to execute.
interface issueIf import armPkg::*; ();

   logic  valid;
   aluOpE aluOp;
   regAddrT rd;
   dataT  operandA;
   dataT  operandB;
   shamtT shamt;
   logic  useShift;

   modport source (
      output valid, aluOp, rd, operandA, operandB, shamt, useShift
   );

   modport sink (
      input valid, aluOp, rd, operandA, operandB, shamt, useShift
   );

endinterface

// ==== src/armPipeline.sv ====
module armPipeline import armPkg::*; #(
   parameter dataT ResetPc = '0
) (
   input  logic    clk,
   input  logic    reset,
   input  logic    i_stall,
   input  instT    i_inst,
   output dataT    o_pc,
   output logic    o_wbValid,
   output regAddrT o_wbAddr,
   output dataT    o_wbData
);

   // ********************
   // internal buses
   // ********************

   regReadIf regRead ();
   issueIf   issue ();

   // ********************
   // stages
   // ********************

   decodeStage #(
      .ResetPc (ResetPc)
   ) u_decode (
      .clk     (clk),
      .reset   (reset),
      .i_stall (i_stall),
      .i_inst  (i_inst),
      .o_pc    (o_pc),
      .rd      (regRead.requester),
      .iss     (issue.source)
   );

   // the write port seen outside is the same one that updates the registers.
   registerFile u_regFile (
      .clk      (clk),
      .reset    (reset),
      .rd       (regRead.responder),
      .i_wrEn   (o_wbValid),
      .i_wrAddr (o_wbAddr),
      .i_wrData (o_wbData)
   );

   executeStage u_execute (
      .clk      (clk),
      .reset    (reset),
      .i_stall  (i_stall),
      .iss      (issue.sink),
      .o_wrEn   (o_wbValid),
      .o_wrAddr (o_wbAddr),
      .o_wrData (o_wbData)
   );

endmodule

// ==== src/armPkg.sv ====
package armPkg;

   // ********************
   // widths and vector types
   // ********************

   localparam int DataWidth    = 32;
   localparam int RegAddrWidth = 4;
   localparam int ShamtWidth   = 5;

   typedef logic [DataWidth-1:0]    dataT;
   typedef logic [DataWidth-1:0]    instT;
   typedef logic [RegAddrWidth-1:0] regAddrT;
   typedef logic [ShamtWidth-1:0]   shamtT;

   // the encodings are the ARM data-processing opcodes.
   typedef enum logic [3:0] {
      AluAnd = 4'd0,
      AluSub = 4'd2,
      AluAdd = 4'd4,
      AluOrr = 4'd12,
      AluMov = 4'd13
   } aluOpE;

   // the program counter moves one word per cycle.
   localparam dataT PcStep = 32'd4;

   // ********************
   // instruction fields
   // ********************

   // set for an immediate second operand.
   localparam int ImmFlagBit = 25;

   // low bit of each multi-bit field.
   localparam int OpcodeLsb = 21;
   localparam int RnLsb     = 16;
   localparam int RdLsb     = 12;
   localparam int ShamtLsb  = 7;
   localparam int RmLsb     = 0;

   // the immediate starts at bit 0 and is sign extended.
   localparam int Imm8Width = 8;

endpackage

// ==== src/decodeStage.sv ====
module decodeStage import armPkg::*; #(
   parameter dataT ResetPc = '0
) (
   input  logic clk,
   input  logic reset,
   input  logic i_stall,
   input  instT i_inst,
   output dataT o_pc,
   regReadIf.requester rd,
   issueIf.source      iss
);

   dataT pcReg;
   instT instReg;
   logic instValid;

   logic [$bits(aluOpE)-1:0] opcode;
   regAddrT rnField;
   regAddrT rdField;
   regAddrT rmField;
   shamtT   shamtField;
   logic    immFlag;
   logic [Imm8Width-1:0] imm8;
   dataT    immExt;
   logic    opSupported;

   // ********************
   // fetch
   // ********************

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         pcReg <= ResetPc;
      end else if (!i_stall) begin
         pcReg <= pcReg + PcStep;
      end
   end

   // instValid stays low until the first real instruction has been captured.
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         instReg   <= '0;
         instValid <= 1'b0;
      end else if (!i_stall) begin
         instReg   <= i_inst;
         instValid <= 1'b1;
      end
   end

   assign o_pc = pcReg;

   // ********************
   // decode
   // ********************

   assign opcode     = instReg[OpcodeLsb +: $bits(aluOpE)];
   assign rnField    = instReg[RnLsb +: RegAddrWidth];
   assign rdField    = instReg[RdLsb +: RegAddrWidth];
   assign rmField    = instReg[RmLsb +: RegAddrWidth];
   assign shamtField = instReg[ShamtLsb +: ShamtWidth];
   assign immFlag    = instReg[ImmFlagBit];
   assign imm8       = instReg[Imm8Width-1:0];

   assign immExt = {{(DataWidth-Imm8Width){imm8[Imm8Width-1]}}, imm8};

   // anything outside the five ALU operations still flows down the pipe, but never writes.
   always_comb begin
      case (opcode)
         AluAnd, AluSub, AluAdd, AluOrr, AluMov: opSupported = 1'b1;
         default:                                opSupported = 1'b0;
      endcase
   end

   assign rd.rnAddr = rnField;
   assign rd.rmAddr = rmField;

   assign iss.valid    = instValid && opSupported;
   assign iss.aluOp    = aluOpE'(opcode);
   assign iss.rd       = rdField;
   assign iss.operandA = rd.rnData;
   assign iss.operandB = immFlag ? immExt : rd.rmData;
   assign iss.shamt    = shamtField;
   assign iss.useShift = !immFlag;

endmodule

// ==== src/executeStage.sv ====
module executeStage import armPkg::*; (
   input  logic    clk,
   input  logic    reset,
   input  logic    i_stall,
   issueIf.sink    iss,
   output logic    o_wrEn,
   output regAddrT o_wrAddr,
   output dataT    o_wrData
);

   logic    exValid;
   aluOpE   exAluOp;
   regAddrT exRd;
   dataT    exOperandA;
   dataT    exOperandB;
   shamtT   exShamt;
   logic    exUseShift;

   dataT    aluB;
   dataT    aluResult;

   logic    wbValid;
   regAddrT wbAddr;
   dataT    wbData;

   // ********************
   // issue register
   // ********************

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         exValid    <= 1'b0;
         exAluOp    <= AluAnd;
         exRd       <= '0;
         exOperandA <= '0;
         exOperandB <= '0;
         exShamt    <= '0;
         exUseShift <= 1'b0;
      end else if (!i_stall) begin
         exValid    <= iss.valid;
         exAluOp    <= iss.aluOp;
         exRd       <= iss.rd;
         exOperandA <= iss.operandA;
         exOperandB <= iss.operandB;
         exShamt    <= iss.shamt;
         exUseShift <= iss.useShift;
      end
   end

   // ********************
   // shifter and ALU
   // ********************

   // immediates bypass the shifter.
   assign aluB = exUseShift ? (exOperandB << exShamt) : exOperandB;

   always_comb begin
      case (exAluOp)
         AluAnd:  aluResult = exOperandA & aluB;
         AluSub:  aluResult = exOperandA - aluB;
         AluAdd:  aluResult = exOperandA + aluB;
         AluOrr:  aluResult = exOperandA | aluB;
         AluMov:  aluResult = aluB;
         default: aluResult = '0;
      endcase
   end

   // ********************
   // writeback register
   // ********************

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wbValid <= 1'b0;
         wbAddr  <= '0;
         wbData  <= '0;
      end else if (!i_stall) begin
         wbValid <= exValid;
         wbAddr  <= exRd;
         wbData  <= aluResult;
      end
   end

   // a stalled cycle must not write, otherwise the held result would commit twice.
   assign o_wrEn   = wbValid && !i_stall;
   assign o_wrAddr = wbAddr;
   assign o_wrData = wbData;

endmodule

// ==== src/registerFile.sv ====
module registerFile import armPkg::*; (
   input  logic    clk,
   input  logic    reset,
   regReadIf.responder rd,
   input  logic    i_wrEn,
   input  regAddrT i_wrAddr,
   input  dataT    i_wrData
);

   localparam int NumRegs = 2 ** RegAddrWidth;

   dataT regs [NumRegs];

   // ********************
   // write port
   // ********************

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         for (int i = 0; i < NumRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wrEn) begin
         regs[i_wrAddr] <= i_wrData;
      end
   end

   // ********************
   // read ports
   // ********************

   // reads see the array as it stands.
   // A write in the same cycle only shows up after the edge.
   assign rd.rnData = regs[rd.rnAddr];
   assign rd.rmData = regs[rd.rmAddr];

endmodule

// ==== tb/pipeline_cases.txt ====
# stall instruction wbValid wbAddr wbData, one line per clock cycle, all hex
# the instruction on a stall line is replaced by a random word
0 E3A01005 0 0 00000000
0 E3A020FD 0 0 00000000
0 E280307F 0 0 00000000
0 E3A04080 1 1 00000005
0 E28150FF 1 2 FFFFFFFD
0 E0816002 1 3 0000007F
0 E0437101 1 4 FFFFFF80
0 E0028003 1 5 00000004
0 E1819403 1 6 00000002
0 E021A001 1 7 0000006B
0 E3A01040 1 8 0000007D
0 E281A000 1 9 00007F05
0 E281B001 0 0 00000000
0 E281C002 1 1 00000040
0 E3A0D011 1 A 00000005
0 E045E006 1 B 00000006
1 00000000 0 0 00000000
1 00000000 0 0 00000000
0 E187F008 1 C 00000042
1 00000000 0 0 00000000
0 E089008A 1 D 00000011
0 E1E02001 1 E 00000002
0 E1A0318D 1 F 0000007F
0 E082400E 1 0 00007F0F
1 00000000 0 0 00000000
0 E24F5001 0 0 00000000
0 E0200000 1 3 00000088
0 E0200000 1 4 FFFFFFFF
0 E0200000 1 5 0000007E
1 00000000 0 0 00000000
0 E0200000 0 0 00000000

// ==== tb/tbArmPipeline.sv ====
module tbArmPipeline;

   localparam int ClkPeriod   = 100;
   localparam int DriveDelay  = 10;
   localparam int SampleDelay = 80;
   localparam int PcIncrement = 4;
   localparam CaseFile = "tb/pipeline_cases.txt";

   logic        clk;
   logic        reset;
   logic        stall;
   logic [31:0] inst;
   logic [31:0] pc;
   logic        wbValid;
   logic [3:0]  wbAddr;
   logic [31:0] wbData;

   // one entry per clock cycle, in file order.
   logic        caseStall[$];
   logic [31:0] caseInst[$];
   logic        caseValid[$];
   logic [3:0]  caseAddr[$];
   logic [31:0] caseData[$];
   bit          casesLoaded;

   armPipeline u_dut (
      .clk       (clk),
      .reset     (reset),
      .i_stall   (stall),
      .i_inst    (inst),
      .o_pc      (pc),
      .o_wbValid (wbValid),
      .o_wbAddr  (wbAddr),
      .o_wbData  (wbData)
   );

   // ********************
   // clock
   // ********************

   initial begin
      clk = 1'b0;
      forever begin
         #(ClkPeriod / 2);
         clk = ~clk;
      end
   end

   // ********************
   // helpers
   // ********************

   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
      if (got !== expected) begin
         $display("FAILED at time %0t: %s got 0x%08h expected 0x%08h",
                  $time, name, got, expected);
         $display("SIMULATION FAILED");
         $fatal(1, "stopping at the first mismatch");
      end
   endtask

   // lines that do not hold five hex fields are comments and are skipped.
   task automatic loadCases();
      int fd;
      int count;
      logic [8*160-1:0] line;
      logic [31:0] fStall;
      logic [31:0] fInst;
      logic [31:0] fValid;
      logic [31:0] fAddr;
      logic [31:0] fData;
      fd = $fopen(CaseFile, "r");
      if (fd == 0) begin
         $display("could not open the case file %s", CaseFile);
         $display("SIMULATION FAILED");
         $fatal(1, "case file missing");
      end else begin
         while (!$feof(fd)) begin
            line = '0;
            if ($fgets(line, fd) != 0) begin
               count = $sscanf(line, "%h %h %h %h %h", fStall, fInst, fValid, fAddr, fData);
               if (count == 5) begin
                  caseStall.push_back(fStall[0]);
                  caseInst.push_back(fInst);
                  caseValid.push_back(fValid[0]);
                  caseAddr.push_back(fAddr[3:0]);
                  caseData.push_back(fData);
               end
            end
         end
         $fclose(fd);
         if (caseStall.size() == 0) begin
            $display("the case file %s holds no cases", CaseFile);
            $display("SIMULATION FAILED");
            $fatal(1, "case file empty");
         end else begin
            $display("loaded %0d cycles from %s", caseStall.size(), CaseFile);
            casesLoaded = 1'b1;
         end
      end
   endtask

   // ********************
   // stimulus and checks
   // ********************

   initial begin : mainFlow
      int unsigned seed;
      logic [31:0] expPc;
      int i;
      seed  = 32'hd5f5f967;
      void'($urandom(seed));
      reset = 1'b1;
      stall = 1'b0;
      inst  = '0;
      expPc = '0;
      loadCases();

      // reset spans two rising edges.
      @(posedge clk);
      #SampleDelay;
      checkValue("o_wbValid", wbValid, 1'b0);
      checkValue("o_pc", pc, 32'd0);
      @(posedge clk);
      #DriveDelay;
      reset = 1'b0;

      for (i = 0; i < caseStall.size(); i++) begin
         stall = caseStall[i];
         // while stalled the word on the input must not reach the pipeline.
         if (caseStall[i]) begin
            inst = $urandom();
         end else begin
            inst = caseInst[i];
         end
         #SampleDelay;
         checkValue("o_pc", pc, expPc);
         checkValue("o_wbValid", wbValid, caseValid[i]);
         if (caseValid[i]) begin
            checkValue("o_wbAddr", wbAddr, caseAddr[i]);
            checkValue("o_wbData", wbData, caseData[i]);
         end
         if (!caseStall[i]) begin
            expPc = expPc + PcIncrement;
         end
         @(posedge clk);
         #DriveDelay;
      end

      $display("SIMULATION PASSED");
      $finish;
   end

   // ********************
   // watchdog
   // ********************

   initial begin : watchdog
      time limit;
      wait (casesLoaded);
      limit = (caseStall.size() + 10) * ClkPeriod;
      #(limit);
      $display("timeout, the run did not finish within %0t time units", limit);
      $display("SIMULATION FAILED");
      $fatal(1, "watchdog expired");
   end

endmodule

// ==== vlog.f ====
src/armPkg.sv
src/armIfs.sv
src/decodeStage.sv
src/registerFile.sv
src/executeStage.sv
src/armPipeline.sv
tb/tbArmPipeline.sv
